// File: Makefile
# Verilator build and run of the fetch unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_fetch_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) include/fetch_consts.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx 'Verification passed'

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+include
logic/fetch_pkg.sv
logic/fetch_fifo.sv
logic/prefetch_buffer.sv
logic/instr_out_reg.sv
logic/fetch_unit.sv
sim/imem_model.sv
sim/tb_fetch_unit.sv

// File: include/fetch_consts.svh
// fetch front end constants, included by the RTL and the testbench for FIFO sizing and boot
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// fetch FIFO sizing
////////////////////////////////////////////////////////////////////////////

// number of fetched entries buffered between the bus and decode
// any value of 2 or more is valid
`define FETCH_FIFO_DEPTH 3

////////////////////////////////////////////////////////////////////////////
// reset state
////////////////////////////////////////////////////////////////////////////

// first fetch address after reset, word aligned
`define BOOT_ADDR 32'h0000_0080

`endif

// File: logic/fetch_fifo.sv
// in-order buffer of fetched entries between the bus and decode, cleared in one cycle on branch
`default_nettype none

`include "fetch_consts.svh"

module fetch_fifo
  import fetch_pkg::*;
#(
  parameter int unsigned depth = `FETCH_FIFO_DEPTH
) (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,

  // drops every stored entry on the next edge
  input  wire logic          clear_i,

  input  wire logic          in_valid_i,
  output logic               in_ready_o,
  input  wire fetch_entry_t  in_entry_i,

  output logic               out_valid_o,
  input  wire logic          out_ready_i,
  output fetch_entry_t       out_entry_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [cnt_w-1:0] cnt_t;

  localparam ptr_t last_ptr = ptr_t'(depth - 1);
  localparam cnt_t full_cnt = cnt_t'(depth);

  fetch_entry_t mem_q [depth];
  ptr_t         rd_ptr_q;
  ptr_t         wr_ptr_q;
  cnt_t         count_q;
  logic         push;
  logic         pop;

  // pointers wrap at depth, which need not be a power of two
  function automatic ptr_t ptr_inc(input ptr_t p);
    return (p == last_ptr) ? '0 : p + ptr_t'(1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  // ready from occupancy only
  assign in_ready_o  = (count_q < full_cnt);
  assign out_valid_o = (count_q != '0);

  // oldest entry, read straight from storage
  assign out_entry_o = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_entry_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      // clear wins over a write in the same cycle
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // occupancy only moves when exactly one side transfers
      unique case ({push, pop})
        2'b10:   count_q <= count_q + cnt_t'(1);
        2'b01:   count_q <= count_q - cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // stored entries stay within depth and match the distance between the pointers
  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (count_q <= full_cnt) &&
    ((int'(wr_ptr_q) - int'(rd_ptr_q) + int'(depth)) % int'(depth)
      == int'(count_q) % int'(depth)));

endmodule

`default_nettype wire

// File: logic/fetch_pkg.sv
// shared types of the fetch front end, imported by every fetch RTL module and the testbench
`default_nettype none

package fetch_pkg;

  // instruction address on the bus and in the pipeline
  typedef logic [31:0] addr_t;

  // raw instruction word as returned by memory
  typedef logic [31:0] word_t;

  // one fetched instruction with its address and bus error flag
  // travels from the bus response through the FIFO to decode
  typedef struct packed {
    addr_t addr;
    word_t rdata;
    logic  err;
  } fetch_entry_t;

  // bus side state of the prefetch buffer
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } pf_state_e;

endpackage

`default_nettype wire

// File: logic/fetch_unit.sv
// top level of the instruction fetch front end, bus on one side and decode on the other
`default_nettype none

module fetch_unit
  import fetch_pkg::*;
(
  input  wire logic          clk_i,
  input  wire logic          rst_ni,

  // control from the core
  input  wire logic          req_i,
  input  wire logic          branch_i,
  input  wire addr_t         branch_addr_i,

  // decode side
  input  wire logic          id_ready_i,
  output logic               id_valid_o,
  output fetch_entry_t       id_entry_o,

  output logic               busy_o,

  // instruction bus
  output logic               instr_req_o,
  input  wire logic          instr_gnt_i,
  output addr_t              instr_addr_o,
  input  wire word_t         instr_rdata_i,
  input  wire logic          instr_err_i,
  input  wire logic          instr_rvalid_i
);

  // stream from the fetch FIFO into the instruction register
  logic         pf_valid;
  logic         pf_ready;
  fetch_entry_t pf_entry;

  prefetch_buffer pf0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .out_ready_i    (pf_ready),
    .out_valid_o    (pf_valid),
    .out_entry_o    (pf_entry),
    .busy_o         (busy_o),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .instr_rvalid_i (instr_rvalid_i)
  );

  // a branch also discards the entry waiting for decode
  instr_out_reg out0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (branch_i),
    .in_valid_i  (pf_valid),
    .in_ready_o  (pf_ready),
    .in_entry_i  (pf_entry),
    .out_valid_o (id_valid_o),
    .out_ready_i (id_ready_i),
    .out_entry_o (id_entry_o)
  );

endmodule

`default_nettype wire

// File: logic/instr_out_reg.sv
// single-entry instruction register toward decode, flushed when a branch is taken
`default_nettype none

module instr_out_reg
  import fetch_pkg::*;
(
  input  wire logic          clk_i,
  input  wire logic          rst_ni,

  // empties the register on the next edge
  input  wire logic          flush_i,

  input  wire logic          in_valid_i,
  output logic               in_ready_o,
  input  wire fetch_entry_t  in_entry_i,

  output logic               out_valid_o,
  input  wire logic          out_ready_i,
  output fetch_entry_t       out_entry_o
);

  logic         valid_q;
  fetch_entry_t entry_q;
  logic         load;

  // takes a new entry when empty or when decode consumes the current one
  assign in_ready_o = ~valid_q | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  assign out_valid_o = valid_q;
  assign out_entry_o = entry_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // payload only, qualified by valid_q
  always_ff @(posedge clk_i) begin
    if (load) begin
      entry_q <= in_entry_i;
    end
  end

  // decode may stall but a held entry must not change under it
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(out_entry_o));

endmodule

`default_nettype wire

// File: logic/prefetch_buffer.sv
// prefetch buffer driving the instruction bus, tagging responses and filling the fetch FIFO
`default_nettype none

`include "fetch_consts.svh"

module prefetch_buffer
  import fetch_pkg::*;
(
  input  wire logic          clk_i,
  input  wire logic          rst_ni,

  input  wire logic          req_i,
  input  wire logic          branch_i,
  input  wire addr_t         branch_addr_i,

  // stream toward the instruction register
  input  wire logic          out_ready_i,
  output logic               out_valid_o,
  output fetch_entry_t       out_entry_o,

  output logic               busy_o,

  // instruction bus
  output logic               instr_req_o,
  input  wire logic          instr_gnt_i,
  output addr_t              instr_addr_o,
  input  wire word_t         instr_rdata_i,
  input  wire logic          instr_err_i,
  input  wire logic          instr_rvalid_i
);

  pf_state_e    state_q, state_d;
  addr_t        addr_q;
  addr_t        instr_addr;
  addr_t        fetch_addr;
  addr_t        branch_target;
  addr_t        next_addr;
  logic         addr_pend_q, addr_pend_d;
  logic         addr_load;
  logic         bus_free;
  logic         room_ok;
  logic         issue_ok;
  logic         fifo_push;
  logic         fifo_ready;
  fetch_entry_t fifo_in;

  assign busy_o = (state_q != IDLE) | instr_req_o;

  ////////////////////////////////////////////////////////////////////////////
  // fetch FIFO
  ////////////////////////////////////////////////////////////////////////////

  // responses are tagged with the address of the request that produced them
  assign fifo_in = '{addr: addr_q, rdata: instr_rdata_i, err: instr_err_i};

  // only a live response is pushed, an aborted one never is
  assign fifo_push = (state_q == WAIT_RVALID) & instr_rvalid_i;

  fetch_fifo #(
    .depth (`FETCH_FIFO_DEPTH)
  ) fifo0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (branch_i),
    .in_valid_i  (fifo_push),
    .in_ready_o  (fifo_ready),
    .in_entry_i  (fifo_in),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_entry_o (out_entry_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // fetch address
  ////////////////////////////////////////////////////////////////////////////

  assign branch_target = {branch_addr_i[31:2], 2'b00};

  // a pending target has not been requested yet, so it is fetched as is
  assign fetch_addr = addr_pend_q ? addr_q : {addr_q[31:2], 2'b00} + 32'd4;
  assign next_addr  = branch_i ? branch_target : fetch_addr;

  // a push in the same cycle takes one slot
  // keep a second free one for the new request unless the FIFO drains
  assign room_ok  = fifo_ready & (~fifo_push | ~out_valid_o | out_ready_i);
  assign issue_ok = req_i & (branch_i | room_ok);

  ////////////////////////////////////////////////////////////////////////////
  // bus state machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    instr_req_o = 1'b0;
    instr_addr  = next_addr;
    addr_load   = 1'b0;
    addr_pend_d = addr_pend_q;
    bus_free    = 1'b0;

    unique case (state_q)
      IDLE: begin
        bus_free = 1'b1;
      end
      // request is out, address held until granted
      WAIT_GNT: begin
        instr_req_o = 1'b1;
        // a branch redirects the request still waiting for its grant
        if (!branch_i) begin
          instr_addr = addr_q;
        end
        addr_load = branch_i;
        if (instr_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          bus_free = 1'b1;
          state_d  = IDLE;
        end else if (branch_i) begin
          // response still on its way, drop it when it comes
          addr_load   = 1'b1;
          addr_pend_d = 1'b1;
          state_d     = WAIT_ABORTED;
        end
      end
      WAIT_ABORTED: begin
        if (instr_rvalid_i) begin
          bus_free = 1'b1;
          state_d  = IDLE;
        end else if (branch_i) begin
          addr_load   = 1'b1;
          addr_pend_d = 1'b1;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // bus is free this cycle, start the next request or latch a target
    if (bus_free) begin
      if (issue_ok) begin
        instr_req_o = 1'b1;
        addr_load   = 1'b1;
        addr_pend_d = 1'b0;
        state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
      end else if (branch_i) begin
        addr_load   = 1'b1;
        addr_pend_d = 1'b1;
      end
    end
  end

  assign instr_addr_o = instr_addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      addr_q      <= `BOOT_ADDR;
      // boot address is fetched before any increment
      addr_pend_q <= 1'b1;
    end else begin
      state_q     <= state_d;
      addr_pend_q <= addr_pend_d;
      if (addr_load) begin
        addr_q <= instr_addr;
      end
    end
  end

  // bus protocol: an ungranted request keeps its address unless redirected
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> branch_i || (instr_req_o && $stable(instr_addr_o)));

  // one outstanding request must always find a free FIFO slot
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_push |-> fifo_ready);

endmodule

`default_nettype wire

// File: sim/imem_model.sv
// instruction memory model for the fetch testbench, random grant and response delays
`default_nettype none

module imem_model
  import fetch_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  req_i,
  input  wire addr_t addr_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  output word_t      rdata_o,
  output logic       err_o
);

  timeunit 1ns;
  timeprecision 1ps;

  integer      seed;
  logic [31:0] rnd;
  logic        pend_q;
  logic [1:0]  gnt_wait_q;
  logic [1:0]  resp_wait_q;
  addr_t       addr_q;

  // response due once the wait counter has run out
  assign rvalid_o = pend_q && (resp_wait_q == 2'd0);

  // next request may be granted in the cycle of the previous rvalid
  assign gnt_o = req_i && (gnt_wait_q == 2'd0) && (!pend_q || rvalid_o);

  // word content is the inverted address, upper 4k page of each 8k is faulty
  assign rdata_o = ~addr_q;
  assign err_o   = rvalid_o & addr_q[12];

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seed = 32'hc30d;
      pend_q      <= 1'b0;
      gnt_wait_q  <= 2'd0;
      resp_wait_q <= 2'd0;
      addr_q      <= '0;
    end else begin
      rnd = $random(seed);
      if (rvalid_o) begin
        pend_q <= 1'b0;
      end
      if (gnt_o) begin
        // rvalid 1 to 4 cycles after grant, next grant 0 to 3 cycles late
        pend_q      <= 1'b1;
        addr_q      <= addr_i;
        resp_wait_q <= rnd[1:0];
        gnt_wait_q  <= rnd[3:2];
      end else begin
        if (req_i && gnt_wait_q != 2'd0) begin
          gnt_wait_q <= gnt_wait_q - 2'd1;
        end
        if (pend_q && resp_wait_q != 2'd0) begin
          resp_wait_q <= resp_wait_q - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_fetch_unit.sv
// testbench of the fetch unit, checks fetch order, branch flush, stalls and bus errors
`default_nettype none

`include "fetch_consts.svh"

module tb_fetch_unit
  import fetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_tests       = 6;
  localparam int words_per_test  = 32;
  // words prefetched and then flushed also cost bus time
  localparam int watchdog_cycles = num_tests * (words_per_test + `FETCH_FIFO_DEPTH) * 200;

  logic         clk_i;
  logic         rst_ni;
  logic         req;
  logic         branch;
  addr_t        branch_addr;
  logic         id_ready;
  logic         id_valid;
  fetch_entry_t id_entry;
  logic         busy;
  logic         instr_req;
  logic         instr_gnt;
  addr_t        instr_addr;
  word_t        instr_rdata;
  logic         instr_err;
  logic         instr_rvalid;

  // reference state, owned by the monitor
  addr_t        exp_addr;
  int           delivered;
  logic         held_q;
  fetch_entry_t held_entry;
  logic         bus_pending;
  logic         idle_check;
  integer       seed;

  fetch_unit dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .id_ready_i     (id_ready),
    .id_valid_o     (id_valid),
    .id_entry_o     (id_entry),
    .busy_o         (busy),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .instr_err_i    (instr_err),
    .instr_rvalid_i (instr_rvalid)
  );

  imem_model mem0 (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (instr_req),
    .addr_i   (instr_addr),
    .gnt_o    (instr_gnt),
    .rvalid_o (instr_rvalid),
    .rdata_o  (instr_rdata),
    .err_o    (instr_err)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("timeout after %0d cycles, fetch unit stopped delivering", watchdog_cycles);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  task automatic fail_check(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor, sampled mid cycle where every output has settled
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      exp_addr    = `BOOT_ADDR;
      delivered   = 0;
      held_q      = 1'b0;
      bus_pending = 1'b0;
    end else begin
      if (idle_check) begin
        assert (!instr_req && !id_valid && !busy)
          else fail_check("fetch unit became active while req_i was low");
      end
      // busy while a request is out or a granted one still awaits its response
      assert (busy == (instr_req || bus_pending))
        else fail_check($sformatf("Error: busy_o is %h, expected %h",
                                  busy, instr_req || bus_pending));
      // a stalled entry must survive unchanged until decode takes it
      if (held_q) begin
        assert (id_valid) else fail_check("held entry vanished before decode took it");
        assert (id_entry == held_entry)
          else fail_check($sformatf("Error: id_entry_o changed while held, %h expected %h",
                                    id_entry, held_entry));
      end
      if (id_valid && id_ready && !branch) begin
        assert (id_entry.addr == exp_addr)
          else fail_check($sformatf("Error: id_entry_o.addr is %h, expected %h",
                                    id_entry.addr, exp_addr));
        assert (id_entry.rdata == ~exp_addr)
          else fail_check($sformatf("Error: id_entry_o.rdata is %h, expected %h",
                                    id_entry.rdata, ~exp_addr));
        assert (id_entry.err == exp_addr[12])
          else fail_check($sformatf("Error: id_entry_o.err is %h, expected %h",
                                    id_entry.err, exp_addr[12]));
        exp_addr  = exp_addr + 32'd4;
        delivered = delivered + 1;
      end
      // new path starts at the word aligned target
      if (branch) begin
        exp_addr = {branch_addr[31:2], 2'b00};
      end
      held_q     = id_valid && !id_ready && !branch;
      held_entry = id_entry;
      // one transaction in flight from grant until its rvalid
      if (instr_req && instr_gnt) begin
        bus_pending = 1'b1;
      end else if (instr_rvalid) begin
        bus_pending = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // one cycle, decode ready always or three times in four
  task automatic step(input logic random_ready);
    logic [31:0] rnd;
    @(posedge clk_i);
    #2;
    branch = 1'b0;
    rnd = $random(seed);
    id_ready = random_ready ? (rnd[1:0] != 2'b00) : 1'b1;
  endtask

  task automatic deliver(input int n, input logic random_ready);
    int target;
    target = delivered + n;
    while (delivered < target) begin
      step(random_ready);
    end
  endtask

  // decode holds off in the branch cycle, so nothing old is taken
  task automatic branch_to(input addr_t target);
    @(posedge clk_i);
    #2;
    branch      = 1'b1;
    branch_addr = target;
    id_ready    = 1'b0;
  endtask

  // branch right after a granted or a still waiting request
  task automatic branch_when(input logic want_gnt, input addr_t target);
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      seen = instr_req && (instr_gnt == want_gnt);
    end
    branch_to(target);
  endtask

  initial begin
    logic [31:0] rnd;
    seed        = 32'hc30d;
    rst_ni      = 1'b0;
    req         = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    id_ready    = 1'b0;
    idle_check  = 1'b1;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // quiet while not enabled
    repeat (20) step(1'b0);
    idle_check = 1'b0;
    req = 1'b1;

    // sequential run from the boot address
    deliver(words_per_test, 1'b0);

    // redirect with a response outstanding and with a request waiting
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      branch_when(1'b1, rnd & 32'h0000_1ffe);
      deliver(4, 1'b0);
      rnd = $random(seed);
      branch_when(1'b0, rnd & 32'h0000_1ffe);
      deliver(4, 1'b0);
    end

    // decode stalls at random
    deliver(words_per_test, 1'b1);

    // walk across the start of the faulty page, unaligned target
    branch_to(32'h0000_0fe2);
    deliver(24, 1'b1);

    // random branches on top of random stalls
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      branch_to(rnd & 32'h0000_1fff);
      deliver(5, 1'b1);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
